//--- logic/icache_pkg.sv
// Instruction cache shared types
package icache_pkg;

    // Geometry
    localparam int ADDR_W      = 32;
    localparam int TAG_W       = 23;
    localparam int INDEX_W     = 6;
    localparam int NUM_SETS    = 64;
    localparam int LINE_W      = 64;
    localparam int INST_W      = 32;
    localparam int AGE_W       = 3;
    localparam int MEM_CREDITS = 2;  // Refill slots granted by memory after reset

    // One fetch word seen raw or split into cache fields
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [TAG_W-1:0]   tag;
            logic [INDEX_W-1:0] index;
            logic               word_sel;  // Upper or lower half of the line
            logic [1:0]         byte_off;
        } fields;
    } fetch_addr_t;

    typedef struct packed {
        logic        valid;
        fetch_addr_t addr;
    } fetch_req_t;

    typedef struct packed {
        logic              valid;
        logic [INST_W-1:0] inst;
    } fetch_rsp_t;

    // Line aligned with the low three bits zero
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic              valid;
        logic [LINE_W-1:0] line;
    } mem_rsp_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

endpackage

//--- logic/icache_tag_ram.sv
// Tag store for one way
`timescale 1ns/1ps

module icache_tag_ram import icache_pkg::*; (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic [INDEX_W-1:0] i_index,
    input  logic               i_we,
    input  tag_entry_t         i_wdata,
    output tag_entry_t         o_rdata
);

    logic [TAG_W-1:0]    tag_mem [NUM_SETS];
    logic [NUM_SETS-1:0] valid_q;

    // Valid flags live in flops so reset empties the whole way
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            valid_q <= '0;
        end else if (i_we) begin
            valid_q[i_index] <= i_wdata.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_we) begin
            tag_mem[i_index] <= i_wdata.tag;
        end
        // Read returns the old entry when a write hits the same set
        o_rdata <= '{valid: valid_q[i_index], tag: tag_mem[i_index]};
    end

endmodule

//--- logic/icache_data_ram.sv
// Line store for one way
`timescale 1ns/1ps

module icache_data_ram import icache_pkg::*; (
    input  logic               clk,
    input  logic [INDEX_W-1:0] i_index,
    input  logic               i_we,
    input  logic [LINE_W-1:0]  i_wdata,
    output logic [LINE_W-1:0]  o_rdata
);

    logic [LINE_W-1:0] line_mem [NUM_SETS];

    always_ff @(posedge clk) begin
        if (i_we) begin
            line_mem[i_index] <= i_wdata;
        end
        o_rdata <= line_mem[i_index];  // One cycle read latency
    end

endmodule

//--- logic/icache_age_counters.sv
// Per-set age tracking and victim choice
`timescale 1ns/1ps

module icache_age_counters import icache_pkg::*; (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic [INDEX_W-1:0] i_index,
    input  logic               i_tick,
    input  logic               i_touch_way0,
    input  logic               i_touch_way1,
    input  logic               i_way0_valid,
    input  logic               i_way1_valid,
    output logic               o_victim_way
);

    logic [AGE_W-1:0] age0_q [NUM_SETS];
    logic [AGE_W-1:0] age1_q [NUM_SETS];

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                age0_q[s] <= '0;
                age1_q[s] <= '0;
            end
        end else begin
            for (int s = 0; s < NUM_SETS; s++) begin
                // Touch wins over the tick for its own entry
                if (i_touch_way0 && (i_index == INDEX_W'(s))) begin
                    age0_q[s] <= '0;
                end else if (i_tick && (age0_q[s] != '1)) begin
                    age0_q[s] <= age0_q[s] + AGE_W'(1);
                end
                if (i_touch_way1 && (i_index == INDEX_W'(s))) begin
                    age1_q[s] <= '0;
                end else if (i_tick && (age1_q[s] != '1)) begin
                    age1_q[s] <= age1_q[s] + AGE_W'(1);
                end
            end
        end
    end

    // Empty ways first, then the older one, way 0 on a tie
    always_comb begin
        if (!i_way0_valid) begin
            o_victim_way = 1'b0;
        end else if (!i_way1_valid) begin
            o_victim_way = 1'b1;
        end else if (age1_q[i_index] > age0_q[i_index]) begin
            o_victim_way = 1'b1;
        end else begin
            o_victim_way = 1'b0;
        end
    end

endmodule

//--- logic/icache_ctrl_fsm.sv
// Lookup and refill control
`timescale 1ns/1ps

module icache_ctrl_fsm import icache_pkg::*; (
    input  logic               clk,
    input  logic               i_rst_n,
    input  fetch_req_t         i_fetch_req,
    output fetch_rsp_t         o_fetch_rsp,
    output logic               o_fetch_credit,
    output mem_req_t           o_mem_req,
    input  logic               i_mem_credit,
    input  mem_rsp_t           i_mem_rsp,
    output logic [INDEX_W-1:0] o_index,
    input  tag_entry_t         i_tag0,
    input  tag_entry_t         i_tag1,
    input  logic [LINE_W-1:0]  i_line0,
    input  logic [LINE_W-1:0]  i_line1,
    output logic               o_tag_we0,
    output logic               o_tag_we1,
    output tag_entry_t         o_wtag,
    output logic               o_data_we0,
    output logic               o_data_we1,
    output logic [LINE_W-1:0]  o_wline,
    output logic               o_tick,
    output logic               o_touch0,
    output logic               o_touch1,
    input  logic               i_victim_way
);

    typedef enum logic [2:0] {
        IDLE,
        READ,
        COMPARE,
        MISS,
        WAIT_LINE,
        FILL
    } state_e;

    typedef logic [$clog2(MEM_CREDITS+1)-1:0] credit_t;

    state_e            state_q;
    state_e            state_d;
    fetch_addr_t       req_addr_q;
    logic [LINE_W-1:0] line_q;
    credit_t           mem_credit_q;
    logic [1:0]        rst_seen_q;  // Marks the first cycle out of reset
    logic              accept;
    logic              hit0;
    logic              hit1;
    logic              hit;
    logic              issue;
    logic              fill;
    logic [LINE_W-1:0] hit_line;

    assign accept = (state_q == IDLE) && i_fetch_req.valid;
    assign hit0   = (state_q == COMPARE) && i_tag0.valid
                    && (i_tag0.tag == req_addr_q.fields.tag);
    assign hit1   = (state_q == COMPARE) && i_tag1.valid
                    && (i_tag1.tag == req_addr_q.fields.tag);
    assign hit    = hit0 || hit1;
    assign issue  = (state_q == MISS) && (mem_credit_q != '0);  // Stall here without credit
    assign fill   = (state_q == FILL);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (i_fetch_req.valid) begin
                    state_d = READ;
                end
            end
            READ: begin
                state_d = COMPARE;
            end
            COMPARE: begin
                state_d = hit ? IDLE : MISS;
            end
            MISS: begin
                if (issue) begin
                    state_d = WAIT_LINE;
                end
            end
            WAIT_LINE: begin
                if (i_mem_rsp.valid) begin
                    state_d = FILL;
                end
            end
            FILL: begin
                state_d = READ;  // Repeat the lookup which now hits
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_q      <= IDLE;
            mem_credit_q <= credit_t'(MEM_CREDITS);
            rst_seen_q   <= '0;
        end else begin
            state_q    <= state_d;
            rst_seen_q <= {rst_seen_q[0], 1'b1};
            case ({i_mem_credit, issue})
                2'b10:   mem_credit_q <= mem_credit_q + credit_t'(1);
                2'b01:   mem_credit_q <= mem_credit_q - credit_t'(1);
                default: mem_credit_q <= mem_credit_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr_q <= i_fetch_req.addr;
        end
        if ((state_q == WAIT_LINE) && i_mem_rsp.valid) begin
            line_q <= i_mem_rsp.line;
        end
    end

    assign hit_line         = hit0 ? i_line0 : i_line1;
    assign o_fetch_rsp.valid = hit;
    assign o_fetch_rsp.inst  = req_addr_q.fields.word_sel ? hit_line[LINE_W-1:INST_W]
                                                          : hit_line[INST_W-1:0];
    assign o_fetch_credit   = hit || (rst_seen_q == 2'b01);

    // Clear the byte offset within the line
    assign o_mem_req.valid = issue;
    assign o_mem_req.addr  = req_addr_q.raw & ~ADDR_W'(LINE_W / 8 - 1);

    assign o_index    = req_addr_q.fields.index;
    assign o_tag_we0  = fill && !i_victim_way;
    assign o_tag_we1  = fill && i_victim_way;
    assign o_data_we0 = fill && !i_victim_way;
    assign o_data_we1 = fill && i_victim_way;
    assign o_wtag     = '{valid: 1'b1, tag: req_addr_q.fields.tag};
    assign o_wline    = line_q;

    // Ages move on every accepted fetch and a hit or fill clears its way
    assign o_tick   = accept;
    assign o_touch0 = hit0 || o_tag_we0;
    assign o_touch1 = hit1 || o_tag_we1;

endmodule

//--- logic/icache_top.sv
// Two-way instruction cache
`timescale 1ns/1ps

module icache_top import icache_pkg::*; (
    input  logic       clk,
    input  logic       i_rst_n,
    input  fetch_req_t i_fetch_req,
    output logic       o_fetch_credit,
    output fetch_rsp_t o_fetch_rsp,
    output mem_req_t   o_mem_req,
    input  logic       i_mem_credit,
    input  mem_rsp_t   i_mem_rsp
);

    logic [INDEX_W-1:0] ram_index;
    tag_entry_t         tag0;
    tag_entry_t         tag1;
    tag_entry_t         wtag;
    logic [LINE_W-1:0]  line0;
    logic [LINE_W-1:0]  line1;
    logic [LINE_W-1:0]  wline;
    logic               tag_we0;
    logic               tag_we1;
    logic               data_we0;
    logic               data_we1;
    logic               tick;
    logic               touch0;
    logic               touch1;
    logic               victim_way;

    icache_ctrl_fsm u_ctrl (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_fetch_req    (i_fetch_req),
        .o_fetch_rsp    (o_fetch_rsp),
        .o_fetch_credit (o_fetch_credit),
        .o_mem_req      (o_mem_req),
        .i_mem_credit   (i_mem_credit),
        .i_mem_rsp      (i_mem_rsp),
        .o_index        (ram_index),
        .i_tag0         (tag0),
        .i_tag1         (tag1),
        .i_line0        (line0),
        .i_line1        (line1),
        .o_tag_we0      (tag_we0),
        .o_tag_we1      (tag_we1),
        .o_wtag         (wtag),
        .o_data_we0     (data_we0),
        .o_data_we1     (data_we1),
        .o_wline        (wline),
        .o_tick         (tick),
        .o_touch0       (touch0),
        .o_touch1       (touch1),
        .i_victim_way   (victim_way)
    );

    icache_tag_ram u_tag_ram0 (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_index (ram_index),
        .i_we    (tag_we0),
        .i_wdata (wtag),
        .o_rdata (tag0)
    );

    icache_tag_ram u_tag_ram1 (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_index (ram_index),
        .i_we    (tag_we1),
        .i_wdata (wtag),
        .o_rdata (tag1)
    );

    icache_data_ram u_data_ram0 (
        .clk     (clk),
        .i_index (ram_index),
        .i_we    (data_we0),
        .i_wdata (wline),
        .o_rdata (line0)
    );

    icache_data_ram u_data_ram1 (
        .clk     (clk),
        .i_index (ram_index),
        .i_we    (data_we1),
        .i_wdata (wline),
        .o_rdata (line1)
    );

    // Victim choice sees the valid flags read for the current set
    icache_age_counters u_age (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_index      (ram_index),
        .i_tick       (tick),
        .i_touch_way0 (touch0),
        .i_touch_way1 (touch1),
        .i_way0_valid (tag0.valid),
        .i_way1_valid (tag1.valid),
        .o_victim_way (victim_way)
    );

endmodule

//--- dv/icache_tb.sv
// Instruction cache testbench
`timescale 1ns/1ps

module icache_tb import icache_pkg::*; ();

    logic       clk;
    logic       i_rst_n;
    fetch_req_t i_fetch_req;
    fetch_rsp_t o_fetch_rsp;
    logic       o_fetch_credit;
    mem_req_t   o_mem_req;
    logic       i_mem_credit;
    mem_rsp_t   i_mem_rsp;

    byte         op_kind_q [$];  // F fetch, R reset
    logic [31:0] op_addr_q [$];
    logic [31:0] op_word_q [$];
    int          op_miss_q [$];
    int          op_delay_q [$];
    logic [31:0] mem_addr_q [$];
    logic [63:0] mem_line_q [$];
    int          credit_due_q [$];  // Cycles at which memory frees a slot
    int          cycle;
    int          fetch_total;
    int          core_credits;
    int          credit_cycle;
    int          mem_credits;
    int          refills;
    int          req_cycle;
    int          rsp_cycle;
    int          rsp_due;
    int          cur_delay;
    logic        fetch_busy;
    logic        rsp_seen;
    logic        rsp_pending;
    fetch_rsp_t  rsp_got;
    logic [31:0] exp_line_addr;
    logic [63:0] rsp_line;
    logic [31:0] lcg_state;

    icache_top dut_i (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_fetch_req    (i_fetch_req),
        .o_fetch_credit (o_fetch_credit),
        .o_fetch_rsp    (o_fetch_rsp),
        .o_mem_req      (o_mem_req),
        .i_mem_credit   (i_mem_credit),
        .i_mem_rsp      (i_mem_rsp)
    );

    always #50 clk = ~clk;

    function automatic int next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[30:16]);
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "Stopped at cycle %0d", cycle);
    endtask

    task automatic compare_rsp(input fetch_rsp_t got, input fetch_rsp_t exp);
        if (got !== exp) begin
            report_error($sformatf("Fail o_fetch_rsp: got %h expected %h", got, exp));
        end
    endtask

    task automatic compare_mem_req(input mem_req_t got, input mem_req_t exp);
        if (got !== exp) begin
            report_error($sformatf("Fail o_mem_req: got %h expected %h", got, exp));
        end
    endtask

    task automatic compare_hit_latency(input int got, input int exp);
        if (got != exp) begin
            report_error($sformatf("Fail hit latency: got %h expected %h", got, exp));
        end
    endtask

    task automatic compare_refills(input int got, input int exp);
        if (got != exp) begin
            report_error($sformatf("Fail o_mem_req count: got %h expected %h", got, exp));
        end
    endtask

    task automatic check_mem_req();
        mem_req_t exp;
        int       idx;
        exp.valid = 1'b1;
        exp.addr  = exp_line_addr;
        idx       = -1;
        if (!fetch_busy) begin
            report_error("Memory request issued with no fetch outstanding");
        end
        compare_mem_req(o_mem_req, exp);
        if (mem_credits == 0) begin
            report_error("Memory request issued while the cache held no memory credit");
        end
        for (int i = 0; i < mem_addr_q.size(); i++) begin
            if (mem_addr_q[i] == o_mem_req.addr) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            report_error("Memory request for a line that was never preloaded");
        end
        mem_credits--;
        refills++;
        rsp_line    = mem_line_q[idx];
        rsp_pending = 1'b1;
        rsp_due     = cycle + 1 + next_random() % 6;  // Line comes back 1 to 6 cycles later
        credit_due_q.push_back(cycle + cur_delay);
    endtask

    // Outputs are sampled between rising edges
    task automatic watch_outputs();
        if (!i_rst_n) begin
            if (o_fetch_rsp.valid !== 1'b0 || o_mem_req.valid !== 1'b0) begin
                report_error("Response or memory request seen while reset is asserted");
            end
        end else begin
            if (o_fetch_rsp.valid === 1'b1) begin
                if (!fetch_busy || o_fetch_credit !== 1'b1) begin
                    report_error("Fetch response without a pending fetch or without its credit");
                end
                rsp_got    = o_fetch_rsp;
                rsp_cycle  = cycle;
                rsp_seen   = 1'b1;
                fetch_busy = 1'b0;
            end
            if (o_fetch_credit === 1'b1) begin
                if (core_credits != 0) begin
                    report_error("Fetch credit granted while the core still held one");
                end
                core_credits = 1;
                credit_cycle = cycle;
            end
            if (o_mem_req.valid === 1'b1) begin
                check_mem_req();
            end
        end
    endtask

    task automatic drive_memory();
        int idx;
        idx          = -1;
        i_mem_rsp    = '0;
        i_mem_credit = 1'b0;
        if (rsp_pending && cycle >= rsp_due) begin
            i_mem_rsp.valid = 1'b1;
            i_mem_rsp.line  = rsp_line;
            rsp_pending     = 1'b0;
        end
        for (int i = 0; i < credit_due_q.size(); i++) begin
            if (idx < 0 && credit_due_q[i] <= cycle) begin
                idx = i;
            end
        end
        if (idx >= 0) begin  // One freed slot per cycle at most
            credit_due_q.delete(idx);
            i_mem_credit = 1'b1;
            mem_credits++;
        end
    endtask

    task automatic step();
        @(negedge clk);
        cycle++;
        i_fetch_req.valid = 1'b0;
        watch_outputs();
        drive_memory();
    endtask

    task automatic apply_reset();
        i_rst_n      = 1'b0;
        i_fetch_req  = '0;
        core_credits = 0;
        mem_credits  = MEM_CREDITS;
        fetch_busy   = 1'b0;
        rsp_pending  = 1'b0;
        credit_due_q.delete();
        repeat (16) step();
        i_rst_n = 1'b1;
        step();
        if (core_credits != 1) begin
            report_error("No fetch credit in the first cycle after reset release");
        end
    endtask

    task automatic run_fetch(input int n);
        fetch_rsp_t exp;
        exp.valid = 1'b1;
        exp.inst  = op_word_q[n];
        // A credit may be used from the cycle after it was granted
        while (core_credits == 0 || cycle <= credit_cycle) begin
            step();
        end
        exp_line_addr = op_addr_q[n] & ~32'h7;
        cur_delay     = op_delay_q[n];
        refills       = 0;
        rsp_seen      = 1'b0;
        fetch_busy    = 1'b1;
        core_credits  = 0;
        req_cycle     = cycle;
        i_fetch_req.valid    = 1'b1;
        i_fetch_req.addr.raw = op_addr_q[n];
        while (!rsp_seen) begin
            step();
        end
        compare_rsp(rsp_got, exp);
        compare_refills(refills, op_miss_q[n]);
        if (op_miss_q[n] == 0) begin
            compare_hit_latency(rsp_cycle - req_cycle, 2);
        end
    endtask

    task automatic load_testdata();
        int          fd;
        int          code;
        int          ch;
        int          miss;
        int          delay;
        byte         kind;
        logic [31:0] addr;
        logic [31:0] word;
        logic [63:0] line;
        fd = $fopen("dv/icache_testdata.txt", "r");
        if (fd == 0) begin
            report_error("Cannot open the test data file");
        end
        code = $fscanf(fd, " %c", kind);
        while (code == 1) begin
            case (kind)
                "#": begin
                    ch = $fgetc(fd);
                    while (ch != 10 && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end
                "M": begin
                    code = $fscanf(fd, "%h %h", addr, line);
                    mem_addr_q.push_back(addr);
                    mem_line_q.push_back(line);
                end
                "F": begin
                    code = $fscanf(fd, "%h %h %d %d", addr, word, miss, delay);
                    op_kind_q.push_back(kind);
                    op_addr_q.push_back(addr);
                    op_word_q.push_back(word);
                    op_miss_q.push_back(miss);
                    op_delay_q.push_back(delay);
                    fetch_total++;
                end
                "R": begin
                    op_kind_q.push_back(kind);
                    op_addr_q.push_back('0);
                    op_word_q.push_back('0);
                    op_miss_q.push_back(0);
                    op_delay_q.push_back(0);
                end
                default: begin
                    report_error("Unknown line kind in the test data file");
                end
            endcase
            code = $fscanf(fd, " %c", kind);
        end
        $fclose(fd);
    endtask

    initial begin
        wait (fetch_total > 0);
        #(longint'(fetch_total) * 200 * 100);
        report_error("Watchdog expired before all fetches completed");
    end

    initial begin
        clk          = 1'b0;
        i_rst_n      = 1'b0;
        i_fetch_req  = '0;
        i_mem_rsp    = '0;
        i_mem_credit = 1'b0;
        cycle        = 0;
        fetch_total  = 0;
        credit_cycle = 0;
        lcg_state    = 32'd68418;
        load_testdata();
        apply_reset();
        for (int n = 0; n < op_kind_q.size(); n++) begin
            if (op_kind_q[n] == "R") begin
                apply_reset();
            end else begin
                run_fetch(n);
            end
        end
        $display("TEST OK");
        $finish;
    end

endmodule

//--- dv/icache_testdata.txt
# M <line addr> <64-bit line> preloads one memory line
# F <addr> <expected word> <expect miss> <credit delay> is one fetch and R resets the DUT
M 00000228 A5A500015A5A0001
M 00000448 2222000122220000
M 00000648 3333000133330000
M 00000848 4444000144440000
M 00000A88 5555000155550000
M 00000C90 6666000166660000
M 00000E98 7777000177770000
M 000010A0 8888000188880000
# Cold miss then hits and word select in set 5
F 00000228 5A5A0001 1 3
F 00000228 5A5A0001 0 3
F 0000022C A5A50001 0 3
F 0000022E A5A50001 0 3
# Three tags in set 9 with age based replacement
F 00000448 22220000 1 3
F 00000648 33330000 1 3
F 00000448 22220000 0 3
F 00000848 44440000 1 3
F 00000448 22220000 0 3
F 00000648 33330000 1 3
F 00000848 44440000 1 3
F 00000648 33330000 0 3
F 00000848 44440000 0 3
# Slow credit return on four cold misses
F 00000A8C 55550001 1 60
F 00000C90 66660000 1 60
F 00000E9C 77770001 1 60
F 000010A0 88880000 1 60
F 0000022C A5A50001 0 3
F 00000228 5A5A0001 0 3
# Both set 9 ages saturate so way 0 is evicted on the tie
F 00000448 22220000 1 3
F 00000648 33330000 0 3
F 00000848 44440000 1 3
# Mid-run reset empties the cache
R
F 00000228 5A5A0001 1 3
F 00000228 5A5A0001 0 3
F 0000022C A5A50001 0 3

//--- icache.f
logic/icache_pkg.sv
logic/icache_tag_ram.sv
logic/icache_data_ram.sv
logic/icache_age_counters.sv
logic/icache_ctrl_fsm.sv
logic/icache_top.sv
dv/icache_tb.sv

//--- Bender.yml
package:
  name: icache

sources:
  - logic/icache_pkg.sv
  - logic/icache_tag_ram.sv
  - logic/icache_data_ram.sv
  - logic/icache_age_counters.sv
  - logic/icache_ctrl_fsm.sv
  - logic/icache_top.sv
  - target: simulation
    files:
      - dv/icache_tb.sv
